// File: include/dzMux_params.svh
// Line count, silo sizing, alarm threshold, bit timing and APB register offsets
`ifndef DZMUX_PARAMS_SVH
`define DZMUX_PARAMS_SVH

////////////////////
// Serial lines
////////////////////
`define DZ_LINES 8
// Clock cycles per serial bit time
`define DZ_CLKS_PER_BIT 8

////////////////////
// Receive silo
////////////////////
`define DZ_SILO_DEPTH 64
// Stores since last RBUF read that raise SA
`define DZ_SA_THRESHOLD 16

// APB byte offsets
`define DZ_ADDR_CSR 8'h00
`define DZ_ADDR_RBUF 8'h04

`endif

// File: source/dzPkg.sv
// Shared enum types for the receiver FSM and the register decoder
`default_nettype none

package dzPkg;

   ////////////////////
   // Receiver FSM
   ////////////////////

   // One 8N1 frame per pass
   // IDLE waits for the falling start edge
   // START checks the start bit at mid-bit
   // DATA shifts in eight bits LSB first
   // STOP samples the stop bit and hands off
   typedef enum logic [1:0]
   {
      IDLE  = 2'd0,
      START = 2'd1,
      DATA  = 2'd2,
      STOP  = 2'd3
   } dzRxState_e;

   ////////////////////
   // Register decode
   ////////////////////

   // Unmapped offsets decode to NONE
   typedef enum logic [1:0]
   {
      NONE = 2'd0,
      CSR  = 2'd1,
      RBUF = 2'd2
   } dzRegSel_e;

endpackage

`default_nettype wire

// File: source/dzRxLinesIf.sv
// Receiver bank to silo interface with bank and silo modports
`default_nettype none
`include "dzMux_params.svh"

interface dzRxLinesIf;

   // Line currently visited by the scanner
   logic [2:0]           scan;
   // Scanned line word: FE, two zero bits, line number, character
   logic [13:0]          rxData;
   // Character waiting, one per line
   logic [`DZ_LINES-1:0] rxFull;
   // Taken by the silo, one per line
   logic [`DZ_LINES-1:0] rxClr;

   modport bank
   (
      output scan, rxData, rxFull,
      input  rxClr
   );

   modport silo
   (
      input  scan, rxData, rxFull,
      output rxClr
   );

endinterface

`default_nettype wire

// File: source/dzSiloCsrIf.sv
// Register block to silo interface with regs and silo modports
`default_nettype none

interface dzSiloCsrIf;

   ////////////////////
   // From the registers
   ////////////////////

   // One-cycle silo clear
   logic        clr;
   // Master scan enable
   logic        csrMse;
   // Silo alarm enable
   logic        csrSae;
   // One-cycle pop after an RBUF read
   logic        rbufPop;

   ////////////////////
   // From the silo
   ////////////////////

   // Silo holds at least one word
   logic        rdone;
   // Silo alarm
   logic        sa;
   // DVAL, OVRE, FE, zeros, line, character
   logic [15:0] rbuf;

   modport regs
   (
      output clr, csrMse, csrSae, rbufPop,
      input  rdone, sa, rbuf
   );

   modport silo
   (
      input  clr, csrMse, csrSae, rbufPop,
      output rdone, sa, rbuf
   );

endinterface

`default_nettype wire

// File: source/dzRxUartBank.sv
// Eight 8N1 oversampling receivers, line scanner and scanned-word multiplexer
`default_nettype none
`include "dzMux_params.svh"

module dzRxUartBank
   import dzPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic [`DZ_LINES-1:0] rxd,
   dzRxLinesIf.bank             lines
);

   localparam int CntW = $clog2(`DZ_CLKS_PER_BIT);
   localparam logic [CntW-1:0] MidCnt = CntW'(`DZ_CLKS_PER_BIT / 2 - 1);
   localparam logic [CntW-1:0] EndCnt = CntW'(`DZ_CLKS_PER_BIT - 1);

   // Held characters and flags of all lines
   wire [`DZ_LINES-1:0][7:0] charVec;
   wire [`DZ_LINES-1:0]      feVec;
   wire [`DZ_LINES-1:0]      fullVec;

   logic [2:0] scanCnt;

   ////////////////////
   // Receivers
   ////////////////////

   for (genvar i = 0; i < `DZ_LINES; i++)
   begin : gRx
      dzRxState_e      state;
      logic [1:0]      syncReg;
      logic [CntW-1:0] sampleCnt;
      logic [2:0]      bitCnt;
      logic [7:0]      shiftReg;
      logic [7:0]      holdChar;
      logic            holdFe;
      logic            full;
      logic            rxSync;

      // Second sync stage is the sampled line
      assign rxSync = syncReg[1];

      always_ff @(posedge clk or posedge rst)
      begin
         if (rst)
         begin
            // Line idles high
            syncReg   <= 2'b11;
            state     <= IDLE;
            sampleCnt <= '0;
            bitCnt    <= '0;
            full      <= 1'b0;
         end
         else
         begin
            syncReg <= {syncReg[0], rxd[i]};
            // Silo took the character
            if (lines.rxClr[i])
               full <= 1'b0;
            case (state)
               IDLE:
               begin
                  sampleCnt <= '0;
                  if (!rxSync)
                     state <= START;
               end
               START:
               begin
                  sampleCnt <= sampleCnt + 1'b1;
                  // Glitch shorter than half a bit goes back to idle
                  if (sampleCnt == MidCnt)
                  begin
                     sampleCnt <= '0;
                     bitCnt    <= '0;
                     state     <= rxSync ? IDLE : DATA;
                  end
               end
               DATA:
               begin
                  sampleCnt <= sampleCnt + 1'b1;
                  if (sampleCnt == EndCnt)
                  begin
                     sampleCnt <= '0;
                     bitCnt    <= bitCnt + 1'b1;
                     if (bitCnt == 3'd7)
                        state <= STOP;
                  end
               end
               STOP:
               begin
                  sampleCnt <= sampleCnt + 1'b1;
                  // New character wins over a pending clear
                  if (sampleCnt == EndCnt)
                  begin
                     full  <= 1'b1;
                     state <= IDLE;
                  end
               end
               default:
                  state <= IDLE;
            endcase
         end
      end

      // Payload shift and hold
      always_ff @(posedge clk)
      begin
         if (state == DATA && sampleCnt == EndCnt)
            shiftReg <= {rxSync, shiftReg[7:1]};
         if (state == STOP && sampleCnt == EndCnt)
         begin
            holdChar <= shiftReg;
            holdFe   <= ~rxSync;
         end
      end

      assign charVec[i] = holdChar;
      assign feVec[i]   = holdFe;
      assign fullVec[i] = full;
   end

   ////////////////////
   // Scanner
   ////////////////////

   // Free running, one line per clock
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         scanCnt <= '0;
      else
         scanCnt <= scanCnt + 1'b1;
   end

   assign lines.scan   = scanCnt;
   assign lines.rxFull = fullVec;
   // FE, two zero bits, line number, character
   assign lines.rxData = {feVec[scanCnt], 2'b00, scanCnt, charVec[scanCnt]};

   // Silo clears at most the one scanned line, and only a full one
   assert property (@(posedge clk) disable iff (rst)
      $onehot0(lines.rxClr) && ((lines.rxClr & ~fullVec) == '0))
      else $error("rxClr names a line without a character");

endmodule

`default_nettype wire

// File: source/dzRxSilo.sv
// Receive silo FIFO with overrun marking, silo alarm and RBUF word
`default_nettype none
`include "dzMux_params.svh"

module dzRxSilo
(
   input  logic     clk,
   input  logic     rst,
   dzRxLinesIf.silo lines,
   dzSiloCsrIf.silo csr
);

   localparam int PtrW = $clog2(`DZ_SILO_DEPTH);
   localparam int CntW = $clog2(`DZ_SA_THRESHOLD + 1);
   localparam logic [PtrW-1:0] LastAddr = PtrW'(`DZ_SILO_DEPTH - 1);
   localparam logic [CntW-1:0] SaCount = CntW'(`DZ_SA_THRESHOLD);

   logic            wrEn;
   logic            rdEn;
   logic            empty;
   logic            full;
   logic            overwrite;
   logic [PtrW-1:0] wrPtr;
   logic [PtrW-1:0] rdPtr;
   logic [PtrW-1:0] lastPtr;
   logic [PtrW-1:0] wrAddr;
   // One wider than the pointers, 0 to DZ_SILO_DEPTH
   logic [PtrW:0]   depth;

   // OVRE over the 14-bit receiver word
   logic [14:0]     mem [`DZ_SILO_DEPTH];
   logic [14:0]     headReg;
   logic            dvalReg;

   logic [CntW-1:0] saCnt;
   logic            saReg;

   ////////////////////
   // Store and pop
   ////////////////////

   // Scanned line full and scanning on
   // Held back during clear so the character waits on its line
   assign wrEn = csr.csrMse & lines.rxFull[lines.scan] & ~csr.clr;
   assign rdEn = csr.rbufPop & ~empty;

   assign empty = (depth == '0);
   assign full  = (depth == (PtrW + 1)'(`DZ_SILO_DEPTH));

   // Hand back to the bank in the store cycle
   always_comb
   begin
      lines.rxClr = '0;
      if (wrEn)
         lines.rxClr[lines.scan] = 1'b1;
   end

   // Most recently stored entry
   assign lastPtr = (wrPtr == '0) ? LastAddr : wrPtr - 1'b1;

   // Full with no pop frees nothing, so replace the newest entry
   assign overwrite = wrEn & full & ~rdEn;
   assign wrAddr    = overwrite ? lastPtr : wrPtr;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         depth <= '0;
      end
      else if (csr.clr)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         depth <= '0;
      end
      else
      begin
         if (wrEn && !overwrite)
            wrPtr <= (wrPtr == LastAddr) ? '0 : wrPtr + 1'b1;
         if (rdEn)
            rdPtr <= (rdPtr == LastAddr) ? '0 : rdPtr + 1'b1;
         // Store and pop together leave depth alone
         if (wrEn && !rdEn && !full)
            depth <= depth + 1'b1;
         else if (rdEn && !wrEn)
            depth <= depth - 1'b1;
      end
   end

   ////////////////////
   // Silo array
   ////////////////////

   // Dual port, registered head read
   always_ff @(posedge clk)
   begin
      if (wrEn)
         mem[wrAddr] <= {overwrite, lines.rxData};
      headReg <= mem[rdPtr];
   end

   // DVAL lines up with the registered head word
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dvalReg <= 1'b0;
      else
         dvalReg <= ~empty;
   end

   ////////////////////
   // Silo alarm
   ////////////////////

   // Stores since last pop or clear, not the depth
   // Saturates at the threshold
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         saCnt <= '0;
         saReg <= 1'b0;
      end
      else if (csr.clr || rdEn || !csr.csrSae)
      begin
         saCnt <= '0;
         saReg <= 1'b0;
      end
      else
      begin
         if (wrEn && saCnt != SaCount)
            saCnt <= saCnt + 1'b1;
         if (saCnt == SaCount)
            saReg <= 1'b1;
      end
   end

   assign csr.rbuf  = {dvalReg, headReg};
   assign csr.rdone = dvalReg;
   assign csr.sa    = saReg;

   assert property (@(posedge clk) disable iff (rst)
      depth <= (PtrW + 1)'(`DZ_SILO_DEPTH))
      else $error("Silo depth past capacity");

   // Register block gates pops on RDONE, so one here means they disagree
   assert property (@(posedge clk) disable iff (rst)
      csr.rbufPop |-> !empty)
      else $error("RBUF pop with an empty silo");

endmodule

`default_nettype wire

// File: source/dzApbRegs.sv
// APB slave for CSR and RBUF, clear and pop pulses, receive interrupt
`default_nettype none
`include "dzMux_params.svh"

module dzApbRegs
   import dzPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [15:0] pwdata,
   output logic [15:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic        irq,
   dzSiloCsrIf.regs    csr
);

   dzRegSel_e   sel;
   logic        access;
   logic        rbufRdAccess;
   logic        rbufWait;
   logic        csrWrite;
   logic        mseReg;
   logic        saeReg;
   logic        rieReg;
   logic        clrReg;
   logic [15:0] csrVal;

   ////////////////////
   // Decode
   ////////////////////

   always_comb
   begin
      case (paddr)
         `DZ_ADDR_CSR:  sel = CSR;
         `DZ_ADDR_RBUF: sel = RBUF;
         default:       sel = NONE;
      endcase
   end

   assign access       = psel & penable;
   assign rbufRdAccess = access & ~pwrite & (sel == RBUF);
   assign csrWrite     = access & pwrite & (sel == CSR);

   // One wait cycle on RBUF reads only
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rbufWait <= 1'b0;
      else
         rbufWait <= rbufRdAccess & ~rbufWait;
   end

   assign pready  = access & ~(rbufRdAccess & ~rbufWait);
   // Unmapped offset or RBUF write
   assign pslverr = pready & ((sel == NONE) | ((sel == RBUF) & pwrite));

   // Pop on the completing edge when a word is waiting
   assign csr.rbufPop = rbufRdAccess & rbufWait & csr.rdone;

   ////////////////////
   // CSR
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         mseReg <= 1'b0;
         saeReg <= 1'b0;
         rieReg <= 1'b0;
         clrReg <= 1'b0;
      end
      else
      begin
         // CLR is a pulse
         clrReg <= csrWrite & pwdata[4];
         if (csrWrite)
         begin
            saeReg <= pwdata[12];
            rieReg <= pwdata[6];
            // Clear also stops scanning
            mseReg <= pwdata[5] & ~pwdata[4];
         end
      end
   end

   // SA 13, SAE 12, RDONE 7, RIE 6, MSE 5, CLR 4
   assign csrVal = {2'b00, csr.sa, saeReg, 4'b0000,
                    csr.rdone, rieReg, mseReg, clrReg, 4'b0000};

   always_comb
   begin
      case (sel)
         CSR:     prdata = csrVal;
         RBUF:    prdata = csr.rbuf;
         default: prdata = '0;
      endcase
   end

   assign csr.clr    = clrReg;
   assign csr.csrMse = mseReg;
   assign csr.csrSae = saeReg;

   // Alarm replaces done as the source when SAE is set
   assign irq = rieReg & (saeReg ? csr.sa : csr.rdone);

   // Completion only in an access phase that follows a setup cycle
   assert property (@(posedge clk) disable iff (rst)
      pready |-> psel && penable && $past(psel))
      else $error("PREADY outside an access phase");

   // First access cycle of an RBUF read always waits
   assert property (@(posedge clk) disable iff (rst)
      psel && !penable && !pwrite && sel == RBUF ##1 penable |-> !pready ##1 pready)
      else $error("RBUF read without exactly one wait state");

endmodule

`default_nettype wire

// File: source/dzMux.sv
// Top level joining receiver bank, silo and APB registers
`default_nettype none
`include "dzMux_params.svh"

module dzMux
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic [`DZ_LINES-1:0] rxd,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [7:0]           paddr,
   input  logic [15:0]          pwdata,
   output logic [15:0]          prdata,
   output logic                 pready,
   output logic                 pslverr,
   output logic                 irq
);

   ////////////////////
   // Internal buses
   ////////////////////

   dzRxLinesIf linesIf ();
   dzSiloCsrIf csrIf ();

   // Serial lines in, scanned words out
   dzRxUartBank bank_i
   (
      .clk   (clk),
      .rst   (rst),
      .rxd   (rxd),
      .lines (linesIf.bank)
   );

   // Shared silo between the lines and RBUF
   dzRxSilo silo_i
   (
      .clk   (clk),
      .rst   (rst),
      .lines (linesIf.silo),
      .csr   (csrIf.silo)
   );

   // APB side
   dzApbRegs regs_i
   (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .irq     (irq),
      .csr     (csrIf.regs)
   );

endmodule

`default_nettype wire

// File: verif/dzMuxTb.sv
// Receive multiplexer testbench with clock, reset, serial and APB drivers and checks
`default_nettype none
`include "dzMux_params.svh"

module dzMuxTb;

   // Cycles an APB access may wait for PREADY
   localparam int ApbTimeout = 8;
   // CSR reads before a status wait gives up
   localparam int PollLimit  = 100;

   // CSR fields
   localparam logic [15:0] CsrClr   = 16'h0010;
   localparam logic [15:0] CsrMse   = 16'h0020;
   localparam logic [15:0] CsrRie   = 16'h0040;
   localparam logic [15:0] CsrRdone = 16'h0080;
   localparam logic [15:0] CsrSae   = 16'h1000;
   localparam logic [15:0] CsrSa    = 16'h2000;
   // RBUF DVAL
   localparam logic [15:0] RbufDval = 16'h8000;

   logic                 clk;
   logic                 rst;
   logic [`DZ_LINES-1:0] rxd;
   logic                 psel;
   logic                 penable;
   logic                 pwrite;
   logic [7:0]           paddr;
   logic [15:0]          pwdata;
   logic [15:0]          prdata;
   logic                 pready;
   logic                 pslverr;
   logic                 irq;

   // Expected silo words in arrival order with DVAL set
   logic [15:0] expQ [$];
   // Last RIE value written to the CSR
   logic        rieWritten;
   integer      seed;

   dzMux dzMux_i
   (
      .clk     (clk),
      .rst     (rst),
      .rxd     (rxd),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .irq     (irq)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #2 clk = ~clk;
   end

   ////////////////////
   // Checks
   ////////////////////

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic checkEqual(input string testName, input logic [15:0] expected,
                             input logic [15:0] actual);
      assert (actual === expected)
      else
         abortRun($sformatf("CHECK FAILED %s expected %h actual %h",
                            testName, expected, actual));
   endtask

   // Bus protocol and interrupt source
   assert property (@(posedge clk) disable iff (rst) pready |-> psel && penable)
      else abortRun("PREADY went high outside an APB access phase");
   assert property (@(posedge clk) disable iff (rst) pslverr |-> pready)
      else abortRun("PSLVERR went high without PREADY");
   assert property (@(posedge clk) disable iff (rst) irq |-> rieWritten)
      else abortRun("Interrupt raised while RIE was clear");

   ////////////////////
   // APB driver
   ////////////////////

   // Setup, access, then wait out any wait states
   task automatic apbAccess(input logic write, input logic [7:0] addr,
                            input logic [15:0] data, output logic [15:0] rdData);
      int waitCnt;
      waitCnt = 0;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      while (!pready)
      begin
         waitCnt++;
         if (waitCnt > ApbTimeout)
            abortRun($sformatf("APB access to offset %h never completed", addr));
         @(posedge clk);
      end
      rdData = prdata;
      checkEqual($sformatf("PSLVERR at offset %h", addr), 16'h0000, {15'd0, pslverr});
      // Interrupt enable changes on the completing edge
      if (write && addr == `DZ_ADDR_CSR)
         rieWritten <= data[6];
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apbWrite(input logic [7:0] addr, input logic [15:0] data);
      logic [15:0] unused;
      apbAccess(1'b1, addr, data, unused);
   endtask

   task automatic apbRead(input logic [7:0] addr, output logic [15:0] data);
      apbAccess(1'b0, addr, 16'h0000, data);
   endtask

   // Poll one CSR bit until it reaches a level
   task automatic waitCsrBit(input int bitPos, input logic level, input string what);
      logic [15:0] csrVal;
      int          polls;
      polls = 0;
      apbRead(`DZ_ADDR_CSR, csrVal);
      while (csrVal[bitPos] !== level)
      begin
         polls++;
         if (polls > PollLimit)
            abortRun($sformatf("Timed out waiting for %s", what));
         apbRead(`DZ_ADDR_CSR, csrVal);
      end
   endtask

   ////////////////////
   // Serial driver
   ////////////////////

   // 8N1, LSB first, then two idle bit times
   task automatic sendFrame(input int line, input logic [7:0] data, input logic badStop);
      logic [9:0] frame;
      frame = {~badStop, data, 1'b0};
      for (int b = 0; b < 10; b++)
      begin
         @(posedge clk);
         rxd[line] <= frame[b];
         repeat (`DZ_CLKS_PER_BIT - 1) @(posedge clk);
      end
      @(posedge clk);
      rxd[line] <= 1'b1;
      repeat (2 * `DZ_CLKS_PER_BIT) @(posedge clk);
   endtask

   // Silo model that replaces its newest word with OVRE set when full
   task automatic storeExpected(input int line, input logic [7:0] ch, input logic fe);
      logic [15:0] word;
      word = {1'b1, 1'b0, fe, 2'b00, 3'(line), ch};
      if (expQ.size() == `DZ_SILO_DEPTH)
      begin
         word[14]                 = 1'b1;
         expQ[expQ.size() - 1]    = word;
      end
      else
         expQ.push_back(word);
   endtask

   task automatic sendChar(input int line, input logic badStop, input logic stored,
                           output logic [7:0] ch);
      ch = 8'($random(seed));
      sendFrame(line, ch, badStop);
      if (stored)
         storeExpected(line, ch, badStop);
   endtask

   // Oldest word through RBUF against the model
   task automatic checkHead(input string testName);
      logic [15:0] rdVal;
      logic [15:0] expected;
      if (expQ.size() == 0)
         abortRun({"No expected silo word left for ", testName});
      expected = expQ.pop_front();
      apbRead(`DZ_ADDR_RBUF, rdVal);
      checkEqual(testName, expected, rdVal);
   endtask

   ////////////////////
   // Stimulus
   ////////////////////

   initial
   begin
      logic [15:0] rdVal;
      logic [7:0]  ch;
      logic [7:0]  heldCh;
      seed       = 32'h6f2df41e;
      rieWritten = 1'b0;
      rst     <= 1'b1;
      rxd     <= '1;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= '0;
      pwdata  <= '0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;

      // Reset state
      apbRead(`DZ_ADDR_CSR, rdVal);
      checkEqual("reset CSR", 16'h0000, rdVal);
      apbRead(`DZ_ADDR_RBUF, rdVal);
      checkEqual("reset RBUF DVAL", 16'h0000, rdVal & RbufDval);
      checkEqual("reset irq", 16'h0000, {15'd0, irq});

      // One character on line 3
      apbWrite(`DZ_ADDR_CSR, CsrMse);
      sendChar(3, 1'b0, 1'b1, ch);
      waitCsrBit(7, 1'b1, "RDONE after one character");
      checkHead("single char RBUF");
      apbRead(`DZ_ADDR_RBUF, rdVal);
      checkEqual("single char DVAL after read", 16'h0000, rdVal & RbufDval);

      // Character waits on its line while scanning is off
      apbWrite(`DZ_ADDR_CSR, 16'h0000);
      sendChar(5, 1'b0, 1'b0, heldCh);
      apbRead(`DZ_ADDR_CSR, rdVal);
      checkEqual("MSE clear CSR", 16'h0000, rdVal);
      apbWrite(`DZ_ADDR_CSR, CsrMse);
      storeExpected(5, heldCh, 1'b0);
      waitCsrBit(7, 1'b1, "RDONE after MSE set");
      checkHead("MSE gated RBUF");

      // Arrival order with two low stop bits
      sendChar(0, 1'b0, 1'b1, ch);
      sendChar(7, 1'b1, 1'b1, ch);
      sendChar(2, 1'b0, 1'b1, ch);
      sendChar(6, 1'b1, 1'b1, ch);
      waitCsrBit(7, 1'b1, "RDONE after four characters");
      for (int i = 0; i < 4; i++)
         checkHead($sformatf("arrival order RBUF %0d", i));

      // Silo alarm at the threshold
      apbWrite(`DZ_ADDR_CSR, CsrSae | CsrRie | CsrMse);
      for (int i = 0; i < `DZ_SA_THRESHOLD - 1; i++)
         sendChar(i % `DZ_LINES, 1'b0, 1'b1, ch);
      apbRead(`DZ_ADDR_CSR, rdVal);
      checkEqual("alarm below threshold CSR", CsrSae | CsrRdone | CsrRie | CsrMse, rdVal);
      checkEqual("alarm below threshold irq", 16'h0000, {15'd0, irq});
      sendChar(4, 1'b0, 1'b1, ch);
      waitCsrBit(13, 1'b1, "SA at the threshold");
      apbRead(`DZ_ADDR_CSR, rdVal);
      checkEqual("alarm CSR", CsrSa | CsrSae | CsrRdone | CsrRie | CsrMse, rdVal);
      checkEqual("alarm irq", 16'h0001, {15'd0, irq});
      checkHead("alarm RBUF");
      apbRead(`DZ_ADDR_CSR, rdVal);
      checkEqual("alarm cleared CSR", CsrSae | CsrRdone | CsrRie | CsrMse, rdVal);
      checkEqual("alarm cleared irq", 16'h0000, {15'd0, irq});
      while (expQ.size() > 0)
         checkHead("alarm drain RBUF");
      apbRead(`DZ_ADDR_CSR, rdVal);
      checkEqual("alarm drained CSR", CsrSae | CsrRie | CsrMse, rdVal);

      // One character more than the silo holds
      apbWrite(`DZ_ADDR_CSR, CsrMse);
      for (int i = 0; i < `DZ_SILO_DEPTH + 1; i++)
         sendChar(i % `DZ_LINES, 1'b0, 1'b1, ch);
      for (int i = 0; i < `DZ_SILO_DEPTH; i++)
         checkHead($sformatf("overrun RBUF entry %0d", i + 1));
      apbRead(`DZ_ADDR_CSR, rdVal);
      checkEqual("overrun drained CSR", CsrMse, rdVal);

      // Clear empties the silo and stops scanning
      sendChar(1, 1'b0, 1'b1, ch);
      sendChar(2, 1'b0, 1'b1, ch);
      waitCsrBit(7, 1'b1, "RDONE before clear");
      apbWrite(`DZ_ADDR_CSR, CsrClr | CsrMse);
      expQ.delete();
      waitCsrBit(7, 1'b0, "RDONE to fall after clear");
      apbRead(`DZ_ADDR_CSR, rdVal);
      checkEqual("clear CSR", 16'h0000, rdVal);
      apbRead(`DZ_ADDR_RBUF, rdVal);
      checkEqual("clear RBUF DVAL", 16'h0000, rdVal & RbufDval);

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
source/dzPkg.sv
source/dzRxLinesIf.sv
source/dzSiloCsrIf.sv
source/dzRxUartBank.sv
source/dzRxSilo.sv
source/dzApbRegs.sv
source/dzMux.sv
verif/dzMuxTb.sv

// File: Bender.yml
package:
  name: dz_mux

export_include_dirs:
  - include

sources:
  - files:
      - source/dzPkg.sv
      - source/dzRxLinesIf.sv
      - source/dzSiloCsrIf.sv
      - source/dzRxUartBank.sv
      - source/dzRxSilo.sv
      - source/dzApbRegs.sv
      - source/dzMux.sv
  - target: test
    files:
      - verif/dzMuxTb.sv
